// File: verilog/flag_pkg.sv
`default_nettype none

package flag_pkg;

    localparam int data_width = 32;

    // Condition opcodes, taken rule in cond_select
    typedef enum logic [2:0] {
        cond_zero     = 3'd0,
        cond_nonzero  = 3'd1,
        cond_ones     = 3'd2,
        cond_not_ones = 3'd3,
        cond_mixed    = 3'd4,
        cond_always   = 3'd5,
        cond_never    = 3'd6
    } cond_op_e;

    typedef enum logic {
        gate_nand = 1'b0,
        gate_nor  = 1'b1
    } gate_kind_e;

    // Gates in one tree layer: groups of four, else groups of three and two
    function automatic int group_count(input int n);
        return (n % 4 == 0) ? n / 4 : (n - 1) / 3 + 1;
    endfunction

endpackage

`default_nettype wire

// File: verilog/tree_layer.sv
`timescale 1ns/10ps
`default_nettype none

module tree_layer #(
    parameter int                   num_inputs  = 4,
    parameter int                   num_outputs = 1,
    parameter flag_pkg::gate_kind_e gate        = flag_pkg::gate_nand
) (
    input  wire [num_inputs-1:0]  layer_in,
    output wire [num_outputs-1:0] layer_out
);
    import flag_pkg::*;

    localparam bit is_nand = (gate == gate_nand);

    generate
        // Only a full layer of 4-input groups has four inputs per output,
        // the 3/2 remainder below always has fewer
        if (num_inputs == 4 * num_outputs) begin : g_quad
            for (genvar i = 0; i < num_outputs; i++) begin : g_gate
                if (is_nand) begin : g_nand
                    assign layer_out[i] = ~&layer_in[i*4 +: 4];
                end else begin : g_nor
                    assign layer_out[i] = ~|layer_in[i*4 +: 4];
                end
            end
        end else if (num_inputs % 2 == 1 || num_inputs > 4) begin : g_tri
            if (is_nand) begin : g_nand
                assign layer_out[0] = ~&layer_in[2:0];
            end else begin : g_nor
                assign layer_out[0] = ~|layer_in[2:0];
            end

            if (num_outputs > 1) begin : g_rest
                tree_layer #(
                    .num_inputs  (num_inputs - 3),
                    .num_outputs (num_outputs - 1),
                    .gate        (gate)
                ) i_rest (
                    .layer_in  (layer_in[num_inputs-1:3]),
                    .layer_out (layer_out[num_outputs-1:1])
                );
            end
        end else begin : g_pair
            // Even count of four or less
            if (is_nand) begin : g_nand
                assign layer_out[0] = ~&layer_in[1:0];
            end else begin : g_nor
                assign layer_out[0] = ~|layer_in[1:0];
            end

            if (num_outputs > 1) begin : g_rest
                tree_layer #(
                    .num_inputs  (num_inputs - 2),
                    .num_outputs (num_outputs - 1),
                    .gate        (gate)
                ) i_rest (
                    .layer_in  (layer_in[num_inputs-1:2]),
                    .layer_out (layer_out[num_outputs-1:1])
                );
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/andn.sv
`timescale 1ns/10ps
`default_nettype none

module andn #(
    parameter int num_inputs = 2
) (
    input  wire [num_inputs-1:0] in,
    output wire                  out
);
    import flag_pkg::*;

    localparam int num_nand_outputs = group_count(num_inputs);
    localparam int num_nor_outputs  = group_count(num_nand_outputs);

    wire [num_nand_outputs-1:0] nand_outs;   // Inverted partial ANDs

    tree_layer #(
        .num_inputs  (num_inputs),
        .num_outputs (num_nand_outputs),
        .gate        (gate_nand)
    ) i_nand_layer (
        .layer_in  (in),
        .layer_out (nand_outs)
    );

    generate
        if (num_nand_outputs == 1) begin : g_inv
            assign out = ~nand_outs[0];
        end else begin : g_nor
            wire [num_nor_outputs-1:0] nor_outs;   // True partial ANDs

            tree_layer #(
                .num_inputs  (num_nand_outputs),
                .num_outputs (num_nor_outputs),
                .gate        (gate_nor)
            ) i_nor_layer (
                .layer_in  (nand_outs),
                .layer_out (nor_outs)
            );

            if (num_nor_outputs == 1) begin : g_done
                assign out = nor_outs[0];
            end else begin : g_next
                andn #(.num_inputs(num_nor_outputs)) i_next (.in(nor_outs), .out(out));
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/orn.sv
`timescale 1ns/10ps
`default_nettype none

module orn #(
    parameter int num_inputs = 2
) (
    input  wire [num_inputs-1:0] in,
    output wire                  out
);
    import flag_pkg::*;

    localparam int num_nor_outputs  = group_count(num_inputs);
    localparam int num_nand_outputs = group_count(num_nor_outputs);

    wire [num_nor_outputs-1:0] nor_outs;   // Inverted partial ORs

    tree_layer #(
        .num_inputs  (num_inputs),
        .num_outputs (num_nor_outputs),
        .gate        (gate_nor)
    ) i_nor_layer (
        .layer_in  (in),
        .layer_out (nor_outs)
    );

    generate
        if (num_nor_outputs == 1) begin : g_inv
            assign out = ~nor_outs[0];
        end else begin : g_nand
            wire [num_nand_outputs-1:0] nand_outs;   // True partial ORs

            tree_layer #(
                .num_inputs  (num_nor_outputs),
                .num_outputs (num_nand_outputs),
                .gate        (gate_nand)
            ) i_nand_layer (
                .layer_in  (nor_outs),
                .layer_out (nand_outs)
            );

            if (num_nand_outputs == 1) begin : g_done
                assign out = nand_outs[0];
            end else begin : g_next
                orn #(.num_inputs(num_nand_outputs)) i_next (.in(nand_outs), .out(out));
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: verilog/cond_select.sv
`timescale 1ns/10ps
`default_nettype none

module cond_select (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 in_valid,
    input  wire flag_pkg::cond_op_e cond,
    input  wire                 all_ones,
    input  wire                 any_one,
    output logic                out_valid,
    output logic                zero,
    output logic                ones,
    output logic                taken
);
    import flag_pkg::*;

    logic taken_next;

    always_comb begin
        case (cond)
            cond_zero:     taken_next = ~any_one;
            cond_nonzero:  taken_next = any_one;
            cond_ones:     taken_next = all_ones;
            cond_not_ones: taken_next = ~all_ones;
            cond_mixed:    taken_next = any_one & ~all_ones;
            cond_always:   taken_next = 1'b1;
            default:       taken_next = 1'b0;   // cond_never and unused codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            zero      <= 1'b0;
            ones      <= 1'b0;
            taken     <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin   // Flags hold between strobes
                zero  <= ~any_one;
                ones  <= all_ones;
                taken <= taken_next;
            end
        end
    end

    // The two trees must never disagree
    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> !(ones && zero)
    );

    // All ones on the sampled operand means some bit was one too
    a_ones_implies_any: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && ones) |-> $past(any_one)
    );

endmodule

`default_nettype wire

// File: verilog/flag_unit.sv
`timescale 1ns/10ps
`default_nettype none

module flag_unit (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             in_valid,
    input  wire [flag_pkg::data_width-1:0]  operand,
    input  wire flag_pkg::cond_op_e         cond,
    output wire                             out_valid,
    output wire                             zero,
    output wire                             ones,
    output wire                             taken
);
    import flag_pkg::*;

    wire all_ones;
    wire any_one;

    andn #(.num_inputs(data_width)) i_andn (.in(operand), .out(all_ones));
    orn  #(.num_inputs(data_width)) i_orn  (.in(operand), .out(any_one));

    cond_select i_cond_select (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .cond      (cond),
        .all_ones  (all_ones),
        .any_one   (any_one),
        .out_valid (out_valid),
        .zero      (zero),
        .ones      (ones),
        .taken     (taken)
    );

endmodule

`default_nettype wire

// File: test/flag_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module flag_unit_tb;
    import flag_pkg::*;

    localparam int timeout_cycles = 10;
    localparam int num_random     = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  in_valid;
    logic [data_width-1:0] operand;
    cond_op_e              cond;
    wire                   out_valid;
    wire                   zero;
    wire                   ones;
    wire                   taken;

    // Vectors in flight, oldest first
    logic [data_width-1:0] operand_q[$];
    cond_op_e              cond_q[$];

    logic                  strobe_seen;
    logic                  held_zero  = 1'b0;   // Expected outputs, held between strobes
    logic                  held_ones  = 1'b0;
    logic                  held_taken = 1'b0;
    cond_op_e              held_cond  = cond_never;
    logic [data_width-1:0] popped_operand;
    cond_op_e              popped_cond;

    int                    fd;
    string                 line;
    logic [3:0]            op_raw;
    logic [data_width-1:0] file_operand;
    logic                  file_taken;
    logic [31:0]           seed;
    logic [data_width-1:0] one_hot;
    logic [2:0]            op_bits;

    flag_unit i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .operand   (operand),
        .cond      (cond),
        .out_valid (out_valid),
        .zero      (zero),
        .ones      (ones),
        .taken     (taken)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic expected_taken(input cond_op_e op, input logic [data_width-1:0] v);
        case (op)
            cond_zero:     return v == '0;
            cond_nonzero:  return v != '0;
            cond_ones:     return v == '1;
            cond_not_ones: return v != '1;
            cond_mixed:    return (v != '0) && (v != '1);
            cond_always:   return 1'b1;
            default:       return 1'b0;
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp, act);
            $display("Test failures found");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic check_taken(input cond_op_e op, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t: taken (%s) expected %b actual %b",
                     $time, op.name(), exp, act);
            $display("Test failures found");
            $fatal(1, "Stopped at first error");
        end
    endtask

    task automatic drive_vector(input cond_op_e op, input logic [data_width-1:0] v);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        operand  = v;
        cond     = op;
        operand_q.push_back(v);
        cond_q.push_back(op);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        // Idle bus carries the opposite flags so a missed hold shows up
        cond     = expected_taken(cond, operand) ? cond_never : cond_always;
        operand  = (operand == '0) ? '1 : '0;
    endtask

    // Stop strobing and wait until every pending result has been checked
    task automatic drain_results();
        int waited;
        waited = 0;
        idle_cycle();
        while (operand_q.size() != 0 && waited < timeout_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (operand_q.size() != 0)
            report_failure("Timeout: out_valid did not return all pending results");
    endtask

    always @(posedge clk)
        strobe_seen <= in_valid && rst_n;

    // Outputs settle after the rising edge, so sample them on the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_flag("out_valid", strobe_seen, out_valid);
            if (out_valid) begin
                if (operand_q.size() == 0) begin
                    report_failure("out_valid rose with no vector outstanding");
                end else begin
                    popped_operand = operand_q.pop_front();
                    popped_cond    = cond_q.pop_front();
                    held_zero      = (popped_operand == '0);
                    held_ones      = (popped_operand == '1);
                    held_taken     = expected_taken(popped_cond, popped_operand);
                    held_cond      = popped_cond;
                end
            end
            check_flag("zero", held_zero, zero);
            check_flag("ones", held_ones, ones);
            check_taken(held_cond, held_taken, taken);
        end
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        operand  = '0;
        cond     = cond_never;
        seed     = 32'h78ce;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);   // Idle outputs are checked here

        fd = $fopen("test/flag_unit_stim.txt", "r");
        if (fd == 0)
            report_failure("Cannot open stimulus file test/flag_unit_stim.txt");
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h", op_raw, file_operand, file_taken) != 3 ||
                    op_raw > 4'd6)
                    report_failure($sformatf("Bad stimulus line: %s", line));
                if (file_taken !== expected_taken(cond_op_e'(op_raw[2:0]), file_operand))
                    report_failure($sformatf("Stimulus taken bit breaks the rule: %s", line));
                drive_vector(cond_op_e'(op_raw[2:0]), file_operand);
                drain_results();   // Gap after each file vector
            end
        end
        $fclose(fd);

        // Walking one and walking zero, back to back
        for (int i = 0; i < data_width; i++) begin
            one_hot    = '0;
            one_hot[i] = 1'b1;
            drive_vector(cond_op_e'(3'(i % 7)), one_hot);
            drive_vector(cond_op_e'(3'((i + 3) % 7)), ~one_hot);
        end
        drain_results();

        for (int n = 0; n < num_random; n++) begin
            seed    = lcg_next(seed);
            op_bits = 3'(seed[29:16] % 7);
            case (seed[31:30])
                2'd0:    file_operand = '0;
                2'd1:    file_operand = '1;
                default: begin
                    seed         = lcg_next(seed);
                    file_operand = seed;
                end
            endcase
            drive_vector(cond_op_e'(op_bits), file_operand);
            if (seed[7:5] == 3'd0)
                idle_cycle();
        end
        drain_results();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/flag_pkg.sv
verilog/tree_layer.sv
verilog/andn.sv
verilog/orn.sv
verilog/cond_select.sv
verilog/flag_unit.sv
test/flag_unit_tb.sv

// File: test/flag_unit_stim.txt
# opcode (hex, 0 zero .. 6 never)   operand (hex)   expected taken
# Lines starting with # are skipped
0 00000000 1
0 ffffffff 0
0 00010000 0
1 00000000 0
1 ffffffff 1
1 80000000 1
2 00000000 0
2 ffffffff 1
2 fffffffe 0
3 00000000 1
3 ffffffff 0
3 7fffffff 1
4 00000000 0
4 ffffffff 0
4 12345678 1
5 00000000 1
5 ffffffff 1
5 a5a5a5a5 1
6 00000000 0
6 ffffffff 0
6 5a5a5a5a 0
0 00000001 0
1 00000001 1
2 efffffff 0
3 fffffeff 1
4 00000001 1
4 fffffffe 1
4 80000000 1
2 ffff0000 0
1 0000ffff 1
0 deadbeef 0
3 0000ffff 1
5 00000001 1
6 00000001 0
4 7fffffff 1
0 00000000 1
2 ffffffff 1
3 00000000 1
